// ==== vlog.f ====
src/cmdproc_pkg.sv
src/overrange_counters.sv
src/cmd_receiver.sv
src/spi_sequencer.sv
src/cmd_dispatcher.sv
src/command_processor.sv
dv/tb_command_processor.sv

// ==== Makefile ====
# Verilator build and run of the command processor testbench

VERILATOR ?= verilator
TOP       ?= tb_command_processor
DUT_TOP   ?= command_processor
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= ALL CHECKS PASSED
RTL_FILES  = $(shell grep '^src/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(DUT_TOP) $(RTL_FILES)

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/tb_command_processor.sv ====
/*
 * Testbench for the command processor. Drives random host commands, models the
 * SPI master and the overrange counters, and checks every response beat.
 */
module tb_command_processor import cmdproc_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 100;
	localparam int N_CMDS     = 34; // boot, 3 info, 20 spi, 4 ovr, mode, 4 unknown, version

	logic       clk = 1'b0;
	logic       rstn;
	logic       i_s_tvalid;
	byte_t      i_s_tdata;
	logic       o_s_tready;
	logic       i_m_tready;
	logic       o_m_tvalid;
	word_t      o_m_tdata;
	logic [3:0] o_m_tkeep;
	logic       o_m_tlast;
	byte_t      o_spi_tx;
	logic       o_spi_tx_dv;
	logic       i_spi_tx_ready;
	byte_t      i_spi_rx;
	logic       i_spi_rx_dv;
	logic [7:0] o_spi_cs_n;
	chip_sel_t  o_spi_miso_sel;
	spi_mode_t  o_spi_mode;
	logic       o_spi_reset_n;
	logic [3:0] i_overrange;
	byte_t      i_board;

	word_t      rng = 32'd38460;
	int         checks;
	int         errors;
	int         tests;
	int         err_mark;
	byte_t      tx_log [$];  // strobed bytes
	logic [7:0] cs_log [$];  // cs at each strobe
	chip_sel_t  sel_log [$];
	word_t      resp_q [$];
	byte_t      last_rx;
	logic       take_rst_n;
	word_t      model_ovr [4];

	command_processor dut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic word_t rnd();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	task automatic check(input string name, input word_t exp, input word_t act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == err_mark)
			$display("test %-8s ok", name);
		else
			$display("test %-8s failed with %0d errors", name, errors - err_mark);
		err_mark = errors;
	endtask

	// ----------------------------------------
	// SPI master model, response monitor, counter model
	always begin : spi_master
		byte_t rx_b;
		word_t r;
		@(posedge clk);
		if (rstn && o_spi_tx_dv) begin
			tx_log.push_back(o_spi_tx);
			cs_log.push_back(o_spi_cs_n);
			sel_log.push_back(o_spi_miso_sel);
			@(negedge clk);
			i_spi_tx_ready = 1'b0;
			repeat (1 + rnd() % 5) @(negedge clk); // busy for 2 to 6 cycles
			r = rnd();
			rx_b = r[7:0];
			last_rx = rx_b;
			i_spi_rx = rx_b;
			i_spi_rx_dv = 1'b1;
			@(negedge clk);
			i_spi_rx_dv = 1'b0;
			i_spi_tx_ready = 1'b1;
		end
	end

	always @(posedge clk) begin
		if (rstn && o_m_tvalid)
			check("o_s_tready", 32'd0, word_t'(o_s_tready)); // no host bytes while answering
		if (rstn && o_m_tvalid && i_m_tready) begin
			resp_q.push_back(o_m_tdata);
			take_rst_n = o_spi_reset_n;
			check("o_m_tkeep", 32'hF, word_t'(o_m_tkeep));
			check("o_m_tlast", 32'd1, word_t'(o_m_tlast));
		end
	end

	always @(posedge clk) begin
		for (int i = 0; i < 4; i++)
			if (!rstn)
				model_ovr[i] <= '0;
			else if (i_overrange[i])
				model_ovr[i] <= model_ovr[i] + 32'd1;
	end

	always @(negedge clk) i_m_tready = |(rnd() & 32'h3); // ready 3 cycles in 4

	// ----------------------------------------
	task automatic send_frame(input frame_t f);
		for (int k = 0; k < FRAME_BYTES; k++) begin
			i_s_tvalid = 1'b1;
			i_s_tdata  = f[8*k +: 8];
			do @(posedge clk); while (!o_s_tready);
			@(negedge clk);
		end
		i_s_tvalid = 1'b0;
	endtask

	task automatic wait_resp(output word_t w);
		while (resp_q.size() == 0) @(negedge clk);
		w = resp_q.pop_front();
	endtask

	task automatic run_flags(input int n);
		word_t r;
		repeat (n) begin
			r = rnd();
			i_overrange = r[3:0];
			@(negedge clk);
		end
		i_overrange = '0;
	endtask

	// strobes, chip select and read byte of one transaction
	task automatic check_spi(input word_t tx_bytes, input int n, input chip_sel_t chip,
			input word_t resp);
		logic [7:0] cs_exp;
		cs_exp = 8'hFF;
		cs_exp[chip] = 1'b0;
		check("strobe count", word_t'(n), word_t'(tx_log.size()));
		for (int k = 0; k < n && k < tx_log.size(); k++) begin
			check("o_spi_tx", word_t'(tx_bytes[8*k +: 8]), word_t'(tx_log[k]));
			check("o_spi_cs_n", word_t'(cs_exp), word_t'(cs_log[k]));
			check("o_spi_miso_sel", word_t'(chip), word_t'(sel_log[k]));
		end
		check("o_m_tdata", word_t'(last_rx), resp);
		tx_log.delete();
		cs_log.delete();
		sel_log.delete();
	endtask

	task automatic info_read(input byte_t sel, input byte_t arg2, input word_t exp);
		frame_t f;
		word_t  resp;
		f = {rnd(), rnd()};
		f[23:0] = {arg2, sel, OP_INFO};
		send_frame(f);
		wait_resp(resp);
		check("o_m_tdata", exp, resp);
	endtask

	// ----------------------------------------
	initial begin : watchdog
		#(N_CMDS * 2000 * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", N_CMDS * 2000);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin : main
		frame_t f;
		word_t  resp;
		word_t  r;
		byte_t  b1;
		byte_t  lc;
		int     n_exp;
		rstn = 1'b0;
		i_s_tvalid = 1'b0;
		i_s_tdata = '0;
		i_m_tready = 1'b0;
		i_spi_tx_ready = 1'b1;
		i_spi_rx = '0;
		i_spi_rx_dv = 1'b0;
		i_overrange = '0;
		i_board = '0;
		repeat (10) @(negedge clk);
		check("o_s_tready", 32'd0, word_t'(o_s_tready)); // all idle in reset
		check("o_m_tvalid", 32'd0, word_t'(o_m_tvalid));
		check("o_spi_cs_n", 32'hFF, word_t'(o_spi_cs_n));
		check("o_spi_tx_dv", 32'd0, word_t'(o_spi_tx_dv));
		check("o_spi_reset_n", 32'd1, word_t'(o_spi_reset_n));
		check("o_spi_mode", 32'd0, word_t'(o_spi_mode));
		rstn = 1'b1;

		wait_resp(resp); // ADC power down
		check_spi(32'h0003_0200, 3, 3'd0, resp);
		check("o_spi_cs_n", 32'hFF, word_t'(o_spi_cs_n));
		end_test("boot");

		info_read(INFO_VERSION, 8'd0, 32'd16);
		r = rnd();
		i_board = r[7:0];
		info_read(INFO_BOARD, 8'd0, {4{r[7:0]}});
		info_read(byte_t'(3 + rnd() % 253), 8'd0, 32'd0);
		end_test("info");

		for (int t = 0; t < 20; t++) begin
			r = rnd();
			case (t % 4)
				0: lc = 8'd2;
				1: lc = 8'd3;
				2: lc = 8'd4;
				default: lc = r[7:0]; // anything else means three bytes
			endcase
			f = {rnd(), rnd()};
			f[7:0] = OP_SPI;
			f[63:56] = lc;
			send_frame(f);
			wait_resp(resp);
			n_exp = (lc == 8'd2) ? 2 : (lc == 8'd4) ? 4 : 3;
			check_spi(f[47:16], n_exp, f[10:8], resp);
		end
		end_test("spi");

		for (int i = 0; i < 4; i++) begin
			run_flags(20 + rnd() % 40);
			r = rnd();
			info_read(INFO_OVR, {r[7:2], 2'(i)}, model_ovr[i]); // flags held at zero
		end
		end_test("ovr");

		r = rnd();
		b1 = r[7:0];
		f = {rnd(), rnd()};
		f[15:0] = {b1, OP_MODE};
		send_frame(f);
		wait_resp(resp);
		check("o_m_tdata", word_t'(b1), resp);
		check("o_spi_mode", word_t'(b1[1:0]), word_t'(o_spi_mode));
		check("o_spi_reset_n at take", 32'd0, word_t'(take_rst_n));
		check("o_spi_reset_n after take", 32'd1, word_t'(o_spi_reset_n));
		end_test("mode");

		for (int t = 0; t < 4; t++) begin
			f = {rnd(), rnd()};
			while (f[7:0] >= 8'd2 && f[7:0] <= 8'd4) f = {rnd(), rnd()};
			send_frame(f);
			repeat (50) @(negedge clk);
			check("response count", 32'd0, word_t'(resp_q.size()));
		end
		info_read(INFO_VERSION, 8'd0, 32'd16);
		end_test("unknown");

		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// ==== src/command_processor.sv ====
/*
 * Top level of the board command processor. Host byte stream in, one 32-bit
 * response beat out per command, plus the SPI master strobes and levels.
 */
module command_processor import cmdproc_pkg::*; (
	input  logic               clk,
	input  logic               rstn,
	// host command stream
	input  logic               i_s_tvalid,
	input  byte_t              i_s_tdata,
	output logic               o_s_tready,
	// host response stream
	input  logic               i_m_tready,
	output logic               o_m_tvalid,
	output word_t              o_m_tdata,
	output logic [3:0]         o_m_tkeep,
	output logic               o_m_tlast,
	// SPI master
	output byte_t              o_spi_tx,
	output logic               o_spi_tx_dv,
	input  logic               i_spi_tx_ready,
	input  byte_t              i_spi_rx,
	input  logic               i_spi_rx_dv,
	output logic [N_CHIPS-1:0] o_spi_cs_n,
	output chip_sel_t          o_spi_miso_sel,
	output spi_mode_t          o_spi_mode,
	output logic               o_spi_reset_n,
	// board status
	input  logic [N_OVR-1:0]   i_overrange,
	input  byte_t              i_board
);

	frame_t     frame;
	logic       frame_valid;
	logic       accept;
	logic       spi_start;
	chip_sel_t  spi_chip;
	word_t      spi_tx_bytes;
	byte_t      spi_len_code;
	logic       spi_done;
	byte_t      spi_rx_byte;
	ovr_count_t count0;
	ovr_count_t count1;
	ovr_count_t count2;
	ovr_count_t count3;

	cmd_receiver u_receiver (
		.clk(clk), .rstn(rstn),
		.i_s_tvalid(i_s_tvalid), .i_s_tdata(i_s_tdata), .o_s_tready(o_s_tready),
		.i_accept(accept), .o_frame(frame), .o_frame_valid(frame_valid)
	);

	cmd_dispatcher u_dispatcher (
		.clk(clk), .rstn(rstn),
		.i_frame(frame), .i_frame_valid(frame_valid), .o_accept(accept),
		.i_m_tready(i_m_tready), .o_m_tvalid(o_m_tvalid), .o_m_tdata(o_m_tdata),
		.o_m_tkeep(o_m_tkeep), .o_m_tlast(o_m_tlast),
		.i_board(i_board),
		.i_count0(count0), .i_count1(count1), .i_count2(count2), .i_count3(count3),
		.o_spi_start(spi_start), .o_spi_chip(spi_chip),
		.o_spi_tx_bytes(spi_tx_bytes), .o_spi_len_code(spi_len_code),
		.i_spi_done(spi_done), .i_spi_rx_byte(spi_rx_byte),
		.o_spi_mode(o_spi_mode), .o_spi_reset_n(o_spi_reset_n)
	);

	spi_sequencer u_sequencer (
		.clk(clk), .rstn(rstn),
		.i_start(spi_start), .i_chip(spi_chip),
		.i_tx_bytes(spi_tx_bytes), .i_len_code(spi_len_code),
		.o_spi_tx(o_spi_tx), .o_spi_tx_dv(o_spi_tx_dv), .i_spi_tx_ready(i_spi_tx_ready),
		.i_spi_rx(i_spi_rx), .i_spi_rx_dv(i_spi_rx_dv),
		.o_spi_cs_n(o_spi_cs_n), .o_spi_miso_sel(o_spi_miso_sel),
		.o_done(spi_done), .o_rx_byte(spi_rx_byte)
	);

	overrange_counters u_ovr (
		.clk(clk), .rstn(rstn), .i_overrange(i_overrange),
		.o_count0(count0), .o_count1(count1), .o_count2(count2), .o_count3(count3)
	);

endmodule

// ==== src/cmd_dispatcher.sv ====
/*
 * Command FSM. Runs the bootup SPI write once, then decodes each frame into
 * an info read, an SPI transaction or a mode change and returns one response beat.
 */
module cmd_dispatcher import cmdproc_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  frame_t     i_frame,
	input  logic       i_frame_valid,
	output logic       o_accept,
	input  logic       i_m_tready,
	output logic       o_m_tvalid,
	output word_t      o_m_tdata,
	output logic [3:0] o_m_tkeep,
	output logic       o_m_tlast,
	input  byte_t      i_board,
	input  ovr_count_t i_count0,
	input  ovr_count_t i_count1,
	input  ovr_count_t i_count2,
	input  ovr_count_t i_count3,
	output logic       o_spi_start,
	output chip_sel_t  o_spi_chip,
	output word_t      o_spi_tx_bytes,
	output byte_t      o_spi_len_code,
	input  logic       i_spi_done,
	input  byte_t      i_spi_rx_byte,
	output spi_mode_t  o_spi_mode,
	output logic       o_spi_reset_n
);

	disp_state_t state;
	byte_t       opcode;
	byte_t       arg1;
	byte_t       arg2;
	ovr_count_t  ovr_sel;
	word_t       info_word;

	assign opcode = i_frame[7:0];
	assign arg1   = i_frame[15:8];
	assign arg2   = i_frame[23:16];

	assign o_accept  = (state == ST_IDLE);
	assign o_m_tkeep = {4{o_m_tvalid}}; // every response is a full word
	assign o_m_tlast = o_m_tvalid;

	// ----------------------------------------
	// info read mux
	always_comb begin
		case (arg2[1:0])
			2'd0:    ovr_sel = i_count0;
			2'd1:    ovr_sel = i_count1;
			2'd2:    ovr_sel = i_count2;
			default: ovr_sel = i_count3;
		endcase
	end

	always_comb begin
		case (arg1)
			INFO_VERSION: info_word = word_t'(FW_VERSION);
			INFO_BOARD:   info_word = {4{i_board}};
			INFO_OVR:     info_word = ovr_sel;
			default:      info_word = '0;
		endcase
	end

	// ----------------------------------------
	// control FSM
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state         <= ST_BOOT;
			o_m_tvalid    <= 1'b0;
			o_spi_start   <= 1'b0;
			o_spi_mode    <= '0;
			o_spi_reset_n <= 1'b1;
		end else begin
			o_spi_start <= 1'b0;
			case (state)
				ST_BOOT: begin // power down the ADC once
					o_spi_start <= 1'b1;
					state       <= ST_SPI;
				end
				ST_IDLE: if (i_frame_valid) state <= ST_EXEC;
				ST_EXEC: begin
					case (opcode)
						OP_INFO: begin
							o_m_tvalid <= 1'b1;
							state      <= ST_RESP;
						end
						OP_SPI: begin
							o_spi_start <= 1'b1;
							state       <= ST_SPI;
						end
						OP_MODE: begin
							o_spi_mode    <= arg1[1:0];
							o_spi_reset_n <= 1'b0; // held until the echo is taken
							o_m_tvalid    <= 1'b1;
							state         <= ST_RESP;
						end
						default: state <= ST_IDLE; // unknown, dropped silently
					endcase
				end
				ST_SPI: begin
					if (i_spi_done) begin
						o_m_tvalid <= 1'b1;
						state      <= ST_RESP;
					end
				end
				ST_RESP: begin
					if (i_m_tready) begin
						o_m_tvalid    <= 1'b0;
						o_spi_reset_n <= 1'b1;
						state         <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// response word and SPI request fields
	always_ff @(posedge clk) begin
		case (state)
			ST_BOOT: begin
				o_spi_chip     <= BOOT_CHIP;
				o_spi_tx_bytes <= BOOT_BYTES;
				o_spi_len_code <= '0; // three bytes
			end
			ST_EXEC: begin
				o_spi_chip     <= arg1[2:0];
				o_spi_tx_bytes <= i_frame[47:16]; // bytes 2 to 5
				o_spi_len_code <= i_frame[63:56];
				o_m_tdata      <= (opcode == OP_MODE) ? word_t'(arg1) : info_word;
			end
			ST_SPI: if (i_spi_done) o_m_tdata <= word_t'(i_spi_rx_byte);
			default: ;
		endcase
	end

	a_resp_stable: assert property (@(posedge clk) disable iff (!rstn)
		o_m_tvalid && !i_m_tready |=> o_m_tvalid && $stable(o_m_tdata));

endmodule

// ==== src/spi_sequencer.sv ====
/*
 * Drives one SPI transaction of 2 to 4 bytes through a byte-wide SPI master.
 * Selects the chip, strobes the bytes as the master gets ready and returns
 * the byte read back after the last one.
 */
module spi_sequencer import cmdproc_pkg::*; (
	input  logic               clk,
	input  logic               rstn,
	input  logic               i_start,
	input  chip_sel_t          i_chip,
	input  word_t              i_tx_bytes,
	input  byte_t              i_len_code,
	output byte_t              o_spi_tx,
	output logic               o_spi_tx_dv,
	input  logic               i_spi_tx_ready,
	input  byte_t              i_spi_rx,
	input  logic               i_spi_rx_dv,
	output logic [N_CHIPS-1:0] o_spi_cs_n,
	output chip_sel_t          o_spi_miso_sel,
	output logic               o_done,
	output byte_t              o_rx_byte
);

	spi_state_t state;
	logic [5:0] wait_cnt;   // cs setup and hold timer
	logic [2:0] bytes_left;
	logic [2:0] n_bytes;
	word_t      tx_buf;

	always_comb begin
		case (i_len_code)
			8'd2:    n_bytes = 3'd2;
			8'd4:    n_bytes = 3'd4;
			default: n_bytes = 3'd3;
		endcase
	end

	assign o_spi_tx    = tx_buf[7:0];
	assign o_spi_tx_dv = (state == SP_SEND) && i_spi_tx_ready;

	// ----------------------------------------
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state          <= SP_IDLE;
			wait_cnt       <= '0;
			bytes_left     <= '0;
			o_spi_cs_n     <= '1;
			o_spi_miso_sel <= '0;
			o_done         <= 1'b0;
		end else begin
			o_done <= 1'b0;
			case (state)
				SP_IDLE: begin
					if (i_start) begin
						o_spi_cs_n     <= ~(N_CHIPS'(1) << i_chip);
						o_spi_miso_sel <= i_chip;
						bytes_left     <= n_bytes;
						wait_cnt       <= '0;
						state          <= SP_SETUP;
					end
				end
				SP_SETUP: begin // let cs settle
					if (wait_cnt == 6'(CS_SETUP_CYCLES - 1))
						state <= SP_SEND;
					else
						wait_cnt <= wait_cnt + 1'b1;
				end
				SP_SEND: begin
					if (i_spi_tx_ready) begin
						bytes_left <= bytes_left - 1'b1;
						state      <= (bytes_left == 3'd1) ? SP_READ : SP_WAIT;
					end
				end
				SP_WAIT: state <= SP_SEND; // next byte loads, master drops ready
				SP_READ: begin
					if (i_spi_rx_dv) begin
						wait_cnt <= '0;
						state    <= SP_HOLD;
					end
				end
				SP_HOLD: begin
					if (wait_cnt == 6'(CS_HOLD_CYCLES - 1)) begin
						o_spi_cs_n <= '1;
						o_done     <= 1'b1;
						state      <= SP_IDLE;
					end else begin
						wait_cnt <= wait_cnt + 1'b1;
					end
				end
				default: state <= SP_IDLE;
			endcase
		end
	end

	// byte shifter and read capture
	always_ff @(posedge clk) begin
		if (state == SP_IDLE && i_start)
			tx_buf <= i_tx_bytes;
		else if (state == SP_WAIT)
			tx_buf <= tx_buf >> 8;
		if (state == SP_READ && i_spi_rx_dv)
			o_rx_byte <= i_spi_rx;
	end

	a_strobe_pulse: assert property (@(posedge clk) disable iff (!rstn)
		o_spi_tx_dv |-> !(&o_spi_cs_n) ##1 !o_spi_tx_dv);

	a_one_cs: assert property (@(posedge clk) disable iff (!rstn)
		$countones(~o_spi_cs_n) == ((state == SP_IDLE) ? 0 : 1));

endmodule

// ==== src/cmd_receiver.sv ====
/*
 * Collects eight accepted host bytes into one command frame and flags it
 * for the dispatcher. Bytes are only taken while the dispatcher is idle.
 */
module cmd_receiver import cmdproc_pkg::*; (
	input  logic   clk,
	input  logic   rstn,
	input  logic   i_s_tvalid,
	input  byte_t  i_s_tdata,
	output logic   o_s_tready,
	input  logic   i_accept,
	output frame_t o_frame,
	output logic   o_frame_valid
);

	logic [$clog2(FRAME_BYTES)-1:0] byte_cnt;
	logic                           take;

	// hold off while the finished frame is being handed over
	assign o_s_tready = i_accept && !o_frame_valid;
	assign take       = i_s_tvalid && o_s_tready;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			byte_cnt      <= '0;
			o_frame_valid <= 1'b0;
		end else begin
			o_frame_valid <= 1'b0;
			if (take) begin
				byte_cnt <= byte_cnt + 1'b1; // wraps to zero after the last byte
				if (byte_cnt == $bits(byte_cnt)'(FRAME_BYTES - 1))
					o_frame_valid <= 1'b1;
			end
		end
	end

	// shift in from the top so byte 0 ends up lowest
	always_ff @(posedge clk) begin
		if (take)
			o_frame <= {i_s_tdata, o_frame[$bits(frame_t)-1:8]};
	end

	a_single_pulse: assert property (@(posedge clk) disable iff (!rstn)
		o_frame_valid |=> !o_frame_valid);

endmodule

// ==== src/overrange_counters.sv ====
/*
 * Free-running counts of the cycles each ADC overrange flag is high.
 */
module overrange_counters import cmdproc_pkg::*; (
	input  logic             clk,
	input  logic             rstn,
	input  logic [N_OVR-1:0] i_overrange,
	output ovr_count_t       o_count0,
	output ovr_count_t       o_count1,
	output ovr_count_t       o_count2,
	output ovr_count_t       o_count3
);

	ovr_count_t cnt [N_OVR];

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < N_OVR; i++)
				cnt[i] <= '0;
		end else begin
			for (int i = 0; i < N_OVR; i++)
				if (i_overrange[i]) cnt[i] <= cnt[i] + 1'b1; // wraps
		end
	end

	assign o_count0 = cnt[0];
	assign o_count1 = cnt[1];
	assign o_count2 = cnt[2];
	assign o_count3 = cnt[3];

endmodule

// ==== src/cmdproc_pkg.sv ====
/*
 * Shared widths, opcodes and constants of the digitizer command processor.
 * Imported by every RTL block that decodes frames or drives the SPI side.
 */
package cmdproc_pkg;

	typedef logic [7:0]  byte_t;      // host or SPI byte
	typedef logic [31:0] word_t;      // response word
	typedef logic [63:0] frame_t;     // 8-byte command, byte 0 in the low bits
	typedef logic [2:0]  chip_sel_t;  // SPI chip index
	typedef logic [1:0]  spi_mode_t;
	typedef logic [31:0] ovr_count_t;

	typedef enum logic [2:0] {ST_BOOT, ST_IDLE, ST_EXEC, ST_SPI, ST_RESP} disp_state_t;
	typedef enum logic [2:0] {SP_IDLE, SP_SETUP, SP_SEND, SP_WAIT, SP_READ, SP_HOLD} spi_state_t;

	localparam int FRAME_BYTES     = 8;
	localparam int N_CHIPS         = 8;
	localparam int N_OVR           = 4;
	localparam int FW_VERSION      = 16;
	localparam int CS_SETUP_CYCLES = 11; // cs low to first strobe
	localparam int CS_HOLD_CYCLES  = 36; // read capture to cs high

	// ----------------------------------------
	localparam byte_t OP_INFO      = 8'd2;
	localparam byte_t OP_SPI       = 8'd3;
	localparam byte_t OP_MODE      = 8'd4;
	localparam byte_t INFO_VERSION = 8'd0;
	localparam byte_t INFO_BOARD   = 8'd1;
	localparam byte_t INFO_OVR     = 8'd2;

	localparam chip_sel_t BOOT_CHIP  = 3'd0;          // the ADC
	localparam word_t     BOOT_BYTES = 32'h0003_0200; // 00, 02, 03 sent low byte first

endpackage
